/* src/cpu_pkg.sv */
package cpu_pkg;

	// ----------------------------------------------------------------------
	// Datapath types
	// ----------------------------------------------------------------------
	typedef logic [15:0] word_t;    // Data and instruction word
	typedef logic [3:0]  reg_sel_t; // Register number r0 to r15
	typedef logic [15:0] pc_t;      // Byte address of an instruction
	typedef logic [7:0]  imm_t;     // Low byte of the instruction

	localparam int  NUM_REGS = 16;
	localparam pc_t PC_STEP  = 16'd2; // Instructions are two bytes apart

	// ----------------------------------------------------------------------
	// Opcodes in instr[15:12]
	// ----------------------------------------------------------------------
	// Arithmetic group wraps on overflow
	// Shift amount comes from instr[3:0]
	typedef enum logic [3:0] {
		op_add = 4'b0000,
		op_sub = 4'b0001,
		op_xor = 4'b0010,
		op_sll = 4'b0100,
		op_sra = 4'b0101, // Sign fill
		op_ror = 4'b0110,
		op_nop = 4'b0111, // Any encoding not listed here
		op_lhb = 4'b1010, // Immediate into high byte
		op_llb = 4'b1011, // Immediate into low byte
		op_hlt = 4'b1111
	} opcode_e;

endpackage

/* src/issue_if.sv */
`timescale 1ns/100ps

// Decoded instruction handed from decode to execute
// Execute takes a valid item in the same cycle
interface issue_if;

	logic              valid;   // Item present this cycle
	cpu_pkg::opcode_e  op;      // Already folded to op_nop if unknown
	cpu_pkg::reg_sel_t dst_reg; // Register to write
	cpu_pkg::word_t    opnd_a;  // rs value, or rd value for LLB and LHB
	cpu_pkg::word_t    opnd_b;  // rt value
	cpu_pkg::imm_t     imm;     // instr[7:0]

	// Decode side
	modport src (
		output valid, op, dst_reg, opnd_a, opnd_b, imm
	);

	// Execute side
	modport dst (
		input valid, op, dst_reg, opnd_a, opnd_b, imm
	);

endinterface

/* src/instr_fetch.sv */
`timescale 1ns/100ps

module instr_fetch #(
	parameter int  IMEM_DEPTH = 256,
	localparam int ADDR_W     = $clog2(IMEM_DEPTH)
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,         // Level that lets the PC advance
	input  logic                hlt,         // Sticky halt from execute
	input  logic                imem_we,     // Program load strobe
	input  logic [ADDR_W-1:0]   imem_addr,   // Word index
	input  cpu_pkg::word_t      imem_wdata,
	output cpu_pkg::pc_t        pc_out,
	output logic                fetch_valid, // One strobe per fetched word
	output cpu_pkg::pc_t        fetch_pc,
	output cpu_pkg::word_t      fetch_instr
);

	// ----------------------------------------------------------------------
	// Instruction memory
	// ----------------------------------------------------------------------
	cpu_pkg::word_t    imem [IMEM_DEPTH]; // No reset on the array
	cpu_pkg::pc_t      pc;
	logic              advance;
	logic [ADDR_W-1:0] rd_idx;

	assign advance = run && !hlt;
	assign rd_idx  = pc[ADDR_W:1]; // Byte address to word index
	assign pc_out  = pc;

	// Load port is open in any cycle
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// ----------------------------------------------------------------------
	// PC and fetch strobe
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= advance; // Word appears one cycle after its PC
			if (advance) begin
				pc <= pc + cpu_pkg::PC_STEP;
			end
		end
	end

	// Synchronous read of the word at the current PC
	// PC travels along with it for decode
	always_ff @(posedge clk) begin
		if (advance) begin
			fetch_instr <= imem[rd_idx];
			fetch_pc    <= pc;
		end
	end

	// Odd PC would mean a broken increment or reset value
	a_pc_even : assert property (
		@(posedge clk) disable iff (!rst_n)
		pc[0] == 1'b0
	) else $error("instr_fetch: odd PC %h", pc);

endmodule

/* src/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              fetch_valid,
	input  cpu_pkg::pc_t      fetch_pc,
	input  cpu_pkg::word_t    fetch_instr,
	input  logic              wb_en,   // Write from execute this cycle
	input  cpu_pkg::reg_sel_t wb_reg,
	input  cpu_pkg::word_t    wb_data,
	issue_if.src              issue
);

	// ----------------------------------------------------------------------
	// Field extraction
	// ----------------------------------------------------------------------
	logic [3:0]        op_bits;
	logic              byte_load; // LLB or LHB
	cpu_pkg::reg_sel_t rd;
	cpu_pkg::reg_sel_t rs;
	cpu_pkg::reg_sel_t rt;
	cpu_pkg::reg_sel_t sel_a;
	cpu_pkg::imm_t     imm;
	cpu_pkg::word_t    rf [cpu_pkg::NUM_REGS];
	cpu_pkg::word_t    data_a;
	cpu_pkg::word_t    data_b;
	cpu_pkg::pc_t      next_pc;   // PC expected on the next strobe

	// Unknown encodings fold to op_nop so execute sees a clean enum
	function automatic cpu_pkg::opcode_e to_op(input logic [3:0] code);
		case (code)
			cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_xor,
			cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror,
			cpu_pkg::op_lhb, cpu_pkg::op_llb, cpu_pkg::op_hlt:
				return cpu_pkg::opcode_e'(code);
			default:
				return cpu_pkg::op_nop;
		endcase
	endfunction

	// Register read with write-before-read bypass
	// r0 always reads zero even while it is being written
	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_sel_t sel);
		if (sel == '0) begin
			return '0;
		end
		if (wb_en && wb_reg == sel) begin
			return wb_data; // Result of the instruction one ahead
		end
		return rf[sel];
	endfunction

	assign op_bits   = fetch_instr[15:12];
	assign rd        = fetch_instr[11:8];
	assign rs        = fetch_instr[7:4];
	assign rt        = fetch_instr[3:0];
	assign imm       = fetch_instr[7:0];
	assign byte_load = (op_bits == cpu_pkg::op_llb) || (op_bits == cpu_pkg::op_lhb);
	assign sel_a     = byte_load ? rd : rs; // Byte loads merge into rd

	always_comb begin
		data_a = read_port(sel_a);
		data_b = read_port(rt);
	end

	// ----------------------------------------------------------------------
	// Register file
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_en && wb_reg != '0) begin
			rf[wb_reg] <= wb_data; // r0 writes are dropped here
		end
	end

	// ----------------------------------------------------------------------
	// Decode to execute register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue.valid <= 1'b0;
			next_pc     <= '0;
		end else begin
			issue.valid <= fetch_valid;
			if (fetch_valid) begin
				next_pc <= fetch_pc + cpu_pkg::PC_STEP;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			issue.op      <= to_op(op_bits);
			issue.dst_reg <= rd;
			issue.opnd_a  <= data_a;
			issue.opnd_b  <= data_b;
			issue.imm     <= imm;
		end
	end

	a_valid_known : assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(issue.valid)
	) else $error("decode_stage: issue valid unknown");

	// No branches in this core so fetch must stay strictly sequential
	a_fetch_seq : assert property (
		@(posedge clk) disable iff (!rst_n)
		fetch_valid |-> fetch_pc == next_pc
	) else $error("decode_stage: fetch PC %h, expected %h", fetch_pc, next_pc);

endmodule

/* src/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
	input  logic              clk,
	input  logic              rst_n,
	issue_if.dst              issue,
	output logic              wb_en,        // Combinational write request
	output cpu_pkg::reg_sel_t wb_reg,
	output cpu_pkg::word_t    wb_data,
	output logic              hlt,          // Sticky after HLT
	output logic              retire_valid,
	output cpu_pkg::reg_sel_t retire_reg,
	output cpu_pkg::word_t    retire_data
);

	// ----------------------------------------------------------------------
	// ALU and byte merge
	// ----------------------------------------------------------------------
	cpu_pkg::word_t result;
	logic           writes;   // Opcode writes a register
	logic           is_hlt;
	logic [3:0]     shamt;
	logic [31:0]    ror_wide; // Doubled operand for rotate

	assign shamt    = issue.imm[3:0];
	assign ror_wide = {issue.opnd_a, issue.opnd_a} >> shamt;

	always_comb begin
		result = '0;
		writes = 1'b1;
		is_hlt = 1'b0;
		case (issue.op)
			cpu_pkg::op_add: result = issue.opnd_a + issue.opnd_b; // Wraps
			cpu_pkg::op_sub: result = issue.opnd_a - issue.opnd_b;
			cpu_pkg::op_xor: result = issue.opnd_a ^ issue.opnd_b;
			cpu_pkg::op_sll: result = issue.opnd_a << shamt;
			cpu_pkg::op_sra: result = $signed(issue.opnd_a) >>> shamt;
			cpu_pkg::op_ror: result = ror_wide[15:0];
			cpu_pkg::op_llb: result = {issue.opnd_a[15:8], issue.imm};
			cpu_pkg::op_lhb: result = {issue.imm, issue.opnd_a[7:0]};
			cpu_pkg::op_hlt: begin
				writes = 1'b0;
				is_hlt = 1'b1;
			end
			default: writes = 1'b0; // op_nop
		endcase
	end

	// ----------------------------------------------------------------------
	// Writeback to the register file
	// ----------------------------------------------------------------------
	// Nothing in flight behind HLT may write
	assign wb_en   = issue.valid && writes && !hlt;
	assign wb_reg  = issue.dst_reg;
	assign wb_data = result;

	// ----------------------------------------------------------------------
	// Retire port and halt
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			hlt          <= 1'b0;
		end else begin
			retire_valid <= wb_en; // r0 writes still show up here
			if (issue.valid && is_hlt) begin
				hlt <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb_en) begin
			retire_reg  <= wb_reg;
			retire_data <= wb_data;
		end
	end

	// Once halted the core must stay silent until the next reset
	a_no_retire_after_hlt : assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(hlt) |-> !retire_valid
	) else $error("execute_stage: retire after halt");

endmodule

/* src/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
	parameter int  IMEM_DEPTH = 256,
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH)
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                imem_we,
	input  logic [IMEM_AW-1:0]  imem_addr,  // Word index into instruction memory
	input  cpu_pkg::word_t      imem_wdata,
	output logic                hlt,
	output cpu_pkg::pc_t        pc_out,
	output logic                retire_valid,
	output cpu_pkg::reg_sel_t   retire_reg,
	output cpu_pkg::word_t      retire_data
);

	// Fetch to decode
	logic              fetch_valid;
	cpu_pkg::pc_t      fetch_pc;
	cpu_pkg::word_t    fetch_instr;

	// Execute back to the register file
	logic              wb_en;
	cpu_pkg::reg_sel_t wb_reg;
	cpu_pkg::word_t    wb_data;

	issue_if issue ();

	// ----------------------------------------------------------------------
	// Pipeline stages
	// ----------------------------------------------------------------------
	instr_fetch #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.hlt         (hlt),         // Freezes the PC
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_wdata  (imem_wdata),
		.pc_out      (pc_out),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_instr (fetch_instr)
	);

	decode_stage u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_instr (fetch_instr),
		.wb_en       (wb_en),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.issue       (issue.src)
	);

	execute_stage u_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue.dst),
		.wb_en        (wb_en),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data),
		.hlt          (hlt),
		.retire_valid (retire_valid),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data)
	);

endmodule

/* sim/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// ----------------------------------------------------------------------
// Program store and model results
// ----------------------------------------------------------------------
// Encodings that write rd: arithmetic, shifts, then the byte loads
localparam logic [3:0] WRITERS [8] = '{4'b0000, 4'b0001, 4'b0010, 4'b0100,
	4'b0101, 4'b0110, 4'b1010, 4'b1011};

cpu_pkg::word_t    prog [NUM_TESTS][MAX_LEN];
int                prog_len [NUM_TESTS];
cpu_pkg::reg_sel_t exp_reg [$];  // Retires in program order
cpu_pkg::word_t    exp_data [$];
cpu_pkg::pc_t      exp_hlt_pc;   // Byte address of the HLT

function automatic int rand_below(input int n);
	return int'($unsigned($random(seed)) % n);
endfunction

// Mix 0 arithmetic, 1 shifts and byte loads, 2 chained on prev, 3 anything but HLT
function automatic cpu_pkg::word_t make_instr(input int mix, input bit preload,
		input cpu_pkg::reg_sel_t prev);
	logic [3:0]        code;
	cpu_pkg::reg_sel_t rd;
	cpu_pkg::reg_sel_t rs;
	cpu_pkg::reg_sel_t rt;
	rd = cpu_pkg::reg_sel_t'(rand_below(8)); // r0 to r7 keeps dependencies dense
	rs = cpu_pkg::reg_sel_t'(rand_below(8));
	rt = cpu_pkg::reg_sel_t'(rand_below(8));
	if (preload) begin
		// Give a few registers nonzero values first
		code = WRITERS[6 + rand_below(2)];
		rd   = cpu_pkg::reg_sel_t'(1 + rand_below(7));
		// Any byte immediate so the sign bit gets set too
		rs   = cpu_pkg::reg_sel_t'(rand_below(16));
		rt   = cpu_pkg::reg_sel_t'(rand_below(16));
	end else if (mix == 0) begin
		code = WRITERS[rand_below(3)];
	end else if (mix == 1) begin
		code = WRITERS[3 + rand_below(5)];
		rt   = cpu_pkg::reg_sel_t'(rand_below(16)); // Shift amounts up to 15
	end else if (mix == 2) begin
		code = WRITERS[rand_below(8)];
		rs   = prev;                                 // Always reads the last result
		rt   = (rand_below(2) == 0) ? prev : rt;
		rd   = (rand_below(4) == 0) ? 4'd0 : rd;     // Some writes aimed at r0
	end else begin
		code = 4'(rand_below(15));                   // Unlisted encodings act as no-ops
	end
	return {code, rd, rs, rt};
endfunction

function automatic void build_programs();
	int                len;
	cpu_pkg::word_t    w;
	cpu_pkg::reg_sel_t prev;
	for (int t = 0; t < NUM_TESTS; t++) begin
		len         = 20 + rand_below(MAX_LEN - 19); // HLT included
		prog_len[t] = len;
		prev        = '0;
		for (int i = 0; i < len - 1; i++) begin
			w          = make_instr((t < 3) ? t : 3, i < 4, prev);
			prev       = w[11:8];
			prog[t][i] = w;
		end
		prog[t][len-1] = 16'hf000;
		// Load, run with up to one pause per instruction, then slack
		cycle_limit += (len + 2) + 2 * len + 20;
	end
endfunction

// ----------------------------------------------------------------------
// Architectural model
// ----------------------------------------------------------------------
function automatic cpu_pkg::word_t alu_model(input logic [3:0] code, input cpu_pkg::word_t a,
		input cpu_pkg::word_t b, input logic [7:0] imm);
	cpu_pkg::word_t r;
	r = a;
	case (code)
		4'b0000: r = a + b;                                // ADD wraps
		4'b0001: r = a - b;
		4'b0010: r = a ^ b;
		4'b0100: r = a << imm[3:0];
		4'b0101: repeat (imm[3:0]) r = {r[15], r[15:1]};  // SRA one bit per step
		4'b0110: repeat (imm[3:0]) r = {r[0], r[15:1]};   // ROR
		4'b1010: r = {imm, a[7:0]};                        // LHB
		4'b1011: r = {a[15:8], imm};                       // LLB
		default: r = '0;
	endcase
	return r;
endfunction

function automatic void run_model(input int t);
	cpu_pkg::word_t    regs [16];
	cpu_pkg::word_t    instr;
	cpu_pkg::word_t    a;
	cpu_pkg::reg_sel_t rd;
	bit                writes;
	exp_reg.delete();
	exp_data.delete();
	exp_hlt_pc = '0;
	for (int r = 0; r < 16; r++) begin
		regs[r] = '0; // Cleared by reset
	end
	for (int i = 0; i < prog_len[t]; i++) begin
		instr  = prog[t][i];
		rd     = instr[11:8];
		writes = 1'b0;
		if (instr[15:12] == 4'b1111) begin
			exp_hlt_pc = cpu_pkg::pc_t'(2 * i);
			break;
		end
		for (int k = 0; k < 8; k++) begin
			writes |= (WRITERS[k] == instr[15:12]);
		end
		if (writes) begin
			// 101x are the byte loads, which merge into rd
			a = (instr[15:13] == 3'b101) ? regs[rd] : regs[instr[7:4]];
			exp_reg.push_back(rd);
			exp_data.push_back(alu_model(instr[15:12], a, regs[instr[3:0]], instr[7:0]));
			if (rd != 4'd0) begin
				regs[rd] = exp_data[$]; // r0 reported but never stored
			end
		end
	end
endfunction

`endif

/* sim/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

	localparam int             IMEM_DEPTH  = 256;
	localparam int             IMEM_AW     = $clog2(IMEM_DEPTH);
	localparam int             NUM_TESTS   = 6;
	localparam int             MAX_LEN     = 40;
	localparam cpu_pkg::word_t SHADOW_WORD = 16'h0111; // ADD r1 that must never retire

	logic               clk;
	logic               rst_n;
	logic               run;
	logic               imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	cpu_pkg::word_t     imem_wdata;
	logic               hlt;
	cpu_pkg::pc_t       pc_out;
	logic               retire_valid;
	cpu_pkg::reg_sel_t  retire_reg;
	cpu_pkg::word_t     retire_data;

	int seed         = 32'hf061;
	int cycles       = 0;
	int cycle_limit  = 0; // Summed over all programs
	int tests_passed = 0;
	int tests_failed = 0;
	int errors       = 0;

	`include "cpu_model.svh"

	cpu_top #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.imem_we      (imem_we),
		.imem_addr    (imem_addr),
		.imem_wdata   (imem_wdata),
		.hlt          (hlt),
		.pc_out       (pc_out),
		.retire_valid (retire_valid),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data)
	);

	// ----------------------------------------------------------------------
	// Clock and watchdog
	// ----------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run still going after %0d cycles", cycle_limit);
		$display("Test failures found");
		$finish;
	end

	// ----------------------------------------------------------------------
	// One program from reset to halt
	// ----------------------------------------------------------------------
	task automatic run_test(input int t, input string name, input bit pause);
		int           fails;
		int           idx;
		int           pauses;
		int           len;
		cpu_pkg::pc_t pc_halt;
		fails  = 0;
		idx    = 0;
		pauses = 0;
		len    = prog_len[t];
		run_model(t);
		@(negedge clk);
		rst_n = 1'b0;
		run   = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		if (hlt !== 1'b0) begin
			$display("ERROR %s: hlt after reset expected 0, actual %b", name, hlt);
			fails++;
		end
		if (pc_out !== 16'h0000) begin
			$display("ERROR %s: pc_out after reset expected 0000, actual %h", name, pc_out);
			fails++;
		end
		// Two writing words sit behind HLT and must be dropped by execute
		for (int i = 0; i < len + 2; i++) begin
			imem_we    = 1'b1;
			imem_addr  = IMEM_AW'(i);
			imem_wdata = (i < len) ? prog[t][i] : SHADOW_WORD;
			@(negedge clk);
		end
		imem_we = 1'b0;
		run     = 1'b1;
		while (hlt !== 1'b1) begin
			@(negedge clk);
			if (retire_valid === 1'b1) begin
				if (idx >= exp_reg.size()) begin
					$display("%s: retire of r%0d beyond the %0d the model expects",
						name, retire_reg, exp_reg.size());
					fails++;
				end else if (retire_reg !== exp_reg[idx] || retire_data !== exp_data[idx]) begin
					$display("ERROR %s: retire %0d expected r%0d=%h, actual r%0d=%h", name, idx,
						exp_reg[idx], exp_data[idx], retire_reg, retire_data);
					fails++;
				end
				idx++;
			end
			if (pause) begin
				// Capped so the watchdog budget holds
				if (pauses < len && rand_below(4) == 0) begin
					run = 1'b0;
					pauses++;
				end else begin
					run = 1'b1;
				end
			end
		end
		run     = 1'b1;
		pc_halt = pc_out;
		if (!pause && pc_out !== exp_hlt_pc + 16'd6) begin
			$display("ERROR %s: pc_out at halt expected %h, actual %h", name,
				exp_hlt_pc + 16'd6, pc_out);
			fails++;
		end
		repeat (4) begin
			@(negedge clk);
			if (retire_valid !== 1'b0) begin
				$display("%s: an instruction retired after the halt", name);
				fails++;
			end
			if (hlt !== 1'b1) begin
				$display("ERROR %s: hlt while halted expected 1, actual %b", name, hlt);
				fails++;
			end
			if (pc_out !== pc_halt) begin
				$display("ERROR %s: pc_out while halted expected %h, actual %h", name,
					pc_halt, pc_out);
				fails++;
			end
		end
		if (idx < exp_reg.size()) begin
			$display("%s: only %0d of %0d expected retires appeared", name, idx, exp_reg.size());
			fails++;
		end
		run    = 1'b0;
		errors += fails;
		if (fails == 0) begin
			tests_passed++;
			$display("PASS %s: %0d retires, HLT at %h", name, idx, exp_hlt_pc);
		end else begin
			tests_failed++;
			$display("FAIL %s: %0d errors", name, fails);
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		build_programs();
		run_test(0, "arith", 1'b0);
		run_test(1, "shift_byte", 1'b0);
		run_test(2, "dependency", 1'b0);
		run_test(3, "halt", 1'b0);
		run_test(4, "pause", 1'b1);
		run_test(5, "reset", 1'b0); // Starts from a halted core with live registers
		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
			NUM_TESTS, tests_passed, tests_failed, errors);
		if (tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+sim
src/cpu_pkg.sv
src/issue_if.sv
src/instr_fetch.sv
src/decode_stage.sv
src/execute_stage.sv
src/cpu_top.sv
sim/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module cpu_tb -Mdir obj_dir || exit 1
out=$(./obj_dir/Vcpu_tb)
echo "$out"
echo "$out" | grep -qx "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
